// File: Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
RTL_TOP   ?= ooo_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
logic/ooo_pkg.sv
logic/rename_regfile.sv
logic/reorder_buffer.sv
logic/rs_slot.sv
logic/issue_unit.sv
logic/ooo_core.sv
verification/ooo_core_asserts.sv
verification/ooo_core_tb.sv

// File: logic/issue_unit.sv
`default_nettype none

module issue_unit import ooo_pkg::*; #(
    parameter int SLOT_NUM = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             in_valid,
    input  logic                             rob_full,
    input  logic [SLOT_NUM-1:0]              slot_busy,
    input  logic [SLOT_NUM-1:0]              slot_ready,
    input  op_t  [SLOT_NUM-1:0]              iss_op,
    input  logic [SLOT_NUM-1:0][DATA_W-1:0]  iss_imm,
    input  logic [SLOT_NUM-1:0][TAG_W-1:0]   iss_tag,
    input  logic [SLOT_NUM-1:0][DATA_W-1:0]  iss_v1,
    input  logic [SLOT_NUM-1:0][DATA_W-1:0]  iss_v2,
    output logic                             in_ready,
    output logic [SLOT_NUM-1:0]              slot_load,
    output logic [SLOT_NUM-1:0]              slot_issue,
    output logic                             cdb_valid,
    output logic [TAG_W-1:0]                 cdb_tag,
    output logic [DATA_W-1:0]                cdb_data
);

    localparam int SEL_W = (SLOT_NUM > 1) ? $clog2(SLOT_NUM) : 1;

    logic                live;
    logic [SLOT_NUM-1:0] free;
    logic [SLOT_NUM-1:0] free_low;
    logic [SEL_W-1:0]    sel;
    logic [DATA_W-1:0]   v1;
    logic [DATA_W-1:0]   v2;
    logic [DATA_W-1:0]   alu;

    assign free     = ~slot_busy;
    assign free_low = free & (~free + SLOT_NUM'(1));  // lowest free slot.

    assign in_ready  = live && !rob_full && (|free);
    assign slot_load = (in_valid && in_ready) ? free_low : '0;

    always_comb begin
        sel = '0;
        for (int i = SLOT_NUM - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign slot_issue = (|slot_ready) ? (SLOT_NUM'(1) << sel) : '0;
    assign v1 = iss_v1[sel];
    assign v2 = iss_v2[sel];

    always_comb begin
        case (iss_op[sel])
            op_add:  alu = v1 + v2;
            op_sub:  alu = v1 - v2;
            op_and:  alu = v1 & v2;
            op_or:   alu = v1 | v2;
            op_xor:  alu = v1 ^ v2;
            op_sll:  alu = v1 << v2[4:0];
            op_addi: alu = v1 + iss_imm[sel];
            default: alu = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live      <= 1'b0;                 // holds off dispatch one cycle after reset.
            cdb_valid <= 1'b0;
        end else begin
            live      <= 1'b1;
            cdb_valid <= (|slot_ready) && !flush;
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag  <= iss_tag[sel];
        cdb_data <= alu;
    end

endmodule

`default_nettype wire

// File: logic/ooo_core.sv
`default_nettype none

module ooo_core import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int SLOT_NUM  = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    input  op_t               in_op,
    input  logic [REG_W-1:0]  in_rd,
    input  logic [REG_W-1:0]  in_rs1,
    input  logic [REG_W-1:0]  in_rs2,
    input  logic [DATA_W-1:0] in_imm,
    output logic              in_ready,
    output logic              commit_valid,
    output logic [REG_W-1:0]  commit_rd,
    output logic [DATA_W-1:0] commit_data
);

    logic [TAG_W-1:0]  alloc_tag;
    logic [TAG_W-1:0]  src1_tag;
    logic [TAG_W-1:0]  src2_tag;
    logic              src1_done;
    logic              src2_done;
    logic [DATA_W-1:0] src1_val;
    logic [DATA_W-1:0] src2_val;
    logic              rob_full;
    logic [TAG_W-1:0]  rob_commit_tag;
    op_t               ld_op;
    logic [DATA_W-1:0] ld_imm;
    logic [TAG_W-1:0]  ld_tag;
    logic [DATA_W-1:0] ld_v1;
    logic [TAG_W-1:0]  ld_q1;
    logic [DATA_W-1:0] ld_v2;
    logic [TAG_W-1:0]  ld_q2;
    logic              cdb_valid;
    logic [TAG_W-1:0]  cdb_tag;
    logic [DATA_W-1:0] cdb_data;

    logic [SLOT_NUM-1:0]             slot_load;
    logic [SLOT_NUM-1:0]             slot_issue;
    logic [SLOT_NUM-1:0]             slot_busy;
    logic [SLOT_NUM-1:0]             slot_ready;
    op_t  [SLOT_NUM-1:0]             iss_op;
    logic [SLOT_NUM-1:0][DATA_W-1:0] iss_imm;
    logic [SLOT_NUM-1:0][TAG_W-1:0]  iss_tag;
    logic [SLOT_NUM-1:0][DATA_W-1:0] iss_v1;
    logic [SLOT_NUM-1:0][DATA_W-1:0] iss_v2;

    rename_regfile i_rename_regfile (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_rd(in_rd), .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm),
        .alloc_tag(alloc_tag),
        .src1_done(src1_done), .src1_val(src1_val),
        .src2_done(src2_done), .src2_val(src2_val),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data), .rob_commit_tag(rob_commit_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .ld_op(ld_op), .ld_imm(ld_imm), .ld_tag(ld_tag),
        .ld_v1(ld_v1), .ld_q1(ld_q1), .ld_v2(ld_v2), .ld_q2(ld_q2)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_reorder_buffer (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .in_rd(in_rd),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .alloc_tag(alloc_tag), .rob_full(rob_full),
        .src1_done(src1_done), .src1_val(src1_val),
        .src2_done(src2_done), .src2_val(src2_val),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data), .rob_commit_tag(rob_commit_tag)
    );

    issue_unit #(.SLOT_NUM(SLOT_NUM)) i_issue_unit (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .rob_full(rob_full),
        .slot_busy(slot_busy), .slot_ready(slot_ready),
        .iss_op(iss_op), .iss_imm(iss_imm), .iss_tag(iss_tag),
        .iss_v1(iss_v1), .iss_v2(iss_v2),
        .in_ready(in_ready), .slot_load(slot_load), .slot_issue(slot_issue),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

    for (genvar i = 0; i < SLOT_NUM; i++) begin : g_slot
        rs_slot i_rs_slot (
            .clk(clk), .rst(rst), .flush(flush),
            .load(slot_load[i]), .issue(slot_issue[i]),
            .ld_op(ld_op), .ld_imm(ld_imm), .ld_tag(ld_tag),
            .ld_v1(ld_v1), .ld_q1(ld_q1), .ld_v2(ld_v2), .ld_q2(ld_q2),
            .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
            .busy(slot_busy[i]), .ready(slot_ready[i]),
            .iss_op(iss_op[i]), .iss_imm(iss_imm[i]), .iss_tag(iss_tag[i]),
            .iss_v1(iss_v1[i]), .iss_v2(iss_v2[i])
        );
    end

endmodule

`default_nettype wire

// File: logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int DATA_W  = 32;
    localparam int REG_NUM = 32;
    localparam int REG_W   = 5;
    localparam int TAG_W   = 4;            // tag 0 means no producer pending.

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_addi                            // rs1 plus immediate, rs2 unused.
    } op_t;

endpackage

`default_nettype wire

// File: logic/rename_regfile.sv
`default_nettype none

module rename_regfile import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_ready,
    input  op_t               in_op,
    input  logic [REG_W-1:0]  in_rd,
    input  logic [REG_W-1:0]  in_rs1,
    input  logic [REG_W-1:0]  in_rs2,
    input  logic [DATA_W-1:0] in_imm,
    input  logic [TAG_W-1:0]  alloc_tag,
    input  logic              src1_done,
    input  logic [DATA_W-1:0] src1_val,
    input  logic              src2_done,
    input  logic [DATA_W-1:0] src2_val,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_data,
    input  logic              commit_valid,
    input  logic [REG_W-1:0]  commit_rd,
    input  logic [DATA_W-1:0] commit_data,
    input  logic [TAG_W-1:0]  rob_commit_tag,
    output logic [TAG_W-1:0]  src1_tag,
    output logic [TAG_W-1:0]  src2_tag,
    output op_t               ld_op,
    output logic [DATA_W-1:0] ld_imm,
    output logic [TAG_W-1:0]  ld_tag,
    output logic [DATA_W-1:0] ld_v1,
    output logic [TAG_W-1:0]  ld_q1,
    output logic [DATA_W-1:0] ld_v2,
    output logic [TAG_W-1:0]  ld_q2
);

    logic [DATA_W-1:0] reg_data [REG_NUM];
    logic [TAG_W-1:0]  reg_tag  [REG_NUM];

    // x0 is never written nor renamed, so its entry stays zero.
    assign src1_tag = reg_tag[in_rs1];
    assign src2_tag = (in_op == op_addi) ? '0 : reg_tag[in_rs2];

    assign ld_op  = in_op;
    assign ld_imm = in_imm;
    assign ld_tag = alloc_tag;

    always_comb begin
        ld_v1 = '0;
        ld_q1 = '0;
        if (src1_tag == '0) begin
            ld_v1 = reg_data[in_rs1];
        end else if (cdb_valid && cdb_tag == src1_tag) begin
            ld_v1 = cdb_data;                  // result on the bus this cycle.
        end else if (src1_done) begin
            ld_v1 = src1_val;                  // done but not yet retired.
        end else begin
            ld_q1 = src1_tag;
        end
    end

    always_comb begin
        ld_v2 = '0;
        ld_q2 = '0;
        if (src2_tag == '0) begin
            ld_v2 = reg_data[in_rs2];
        end else if (cdb_valid && cdb_tag == src2_tag) begin
            ld_v2 = cdb_data;
        end else if (src2_done) begin
            ld_v2 = src2_val;
        end else begin
            ld_q2 = src2_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_data[i] <= '0;
                reg_tag[i]  <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_tag[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_rd != '0) begin
                reg_data[commit_rd] <= commit_data;
                if (reg_tag[commit_rd] == rob_commit_tag) begin
                    reg_tag[commit_rd] <= '0;  // only the youngest producer clears it.
                end
            end
            // a rename in the same cycle overrides the clear above.
            if (in_valid && in_ready && in_rd != '0) begin
                reg_tag[in_rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_ready,
    input  logic [REG_W-1:0]  in_rd,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_data,
    input  logic [TAG_W-1:0]  src1_tag,
    input  logic [TAG_W-1:0]  src2_tag,
    output logic [TAG_W-1:0]  alloc_tag,
    output logic              rob_full,
    output logic              src1_done,
    output logic [DATA_W-1:0] src1_val,
    output logic              src2_done,
    output logic [DATA_W-1:0] src2_val,
    output logic              commit_valid,
    output logic [REG_W-1:0]  commit_rd,
    output logic [DATA_W-1:0] commit_data,
    output logic [TAG_W-1:0]  rob_commit_tag
);

    localparam int PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [REG_W-1:0]     rob_rd  [ROB_DEPTH];
    logic [DATA_W-1:0]    rob_val [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] rob_done;
    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic [PTR_W-1:0]     src1_idx;
    logic [PTR_W-1:0]     src2_idx;
    logic [PTR_W-1:0]     cdb_idx;
    logic                 accept;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // tag is entry index plus one.
    assign src1_idx = PTR_W'(src1_tag - 1'b1);
    assign src2_idx = PTR_W'(src2_tag - 1'b1);
    assign cdb_idx  = PTR_W'(cdb_tag - 1'b1);

    assign accept    = in_valid && in_ready;
    assign alloc_tag = TAG_W'(tail) + 1'b1;
    assign rob_full  = (count == CNT_W'(ROB_DEPTH));

    assign src1_done = (src1_tag != '0) && rob_done[src1_idx];
    assign src1_val  = rob_val[src1_idx];
    assign src2_done = (src2_tag != '0) && rob_done[src2_idx];
    assign src2_val  = rob_val[src2_idx];

    assign commit_valid   = !flush && (count != '0) && rob_done[head];
    assign commit_rd      = rob_rd[head];
    assign commit_data    = rob_val[head];
    assign rob_commit_tag = TAG_W'(head) + 1'b1;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            rob_done <= '0;
        end else begin
            if (accept) begin
                tail           <= ptr_inc(tail);
                rob_done[tail] <= 1'b0;
            end
            if (cdb_valid) begin
                rob_done[cdb_idx] <= 1'b1;
            end
            if (commit_valid) begin
                head <= ptr_inc(head);
            end
            count <= count + CNT_W'(accept) - CNT_W'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rob_rd[tail] <= in_rd;
        end
        if (cdb_valid) begin
            rob_val[cdb_idx] <= cdb_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/rs_slot.sv
`default_nettype none

module rs_slot import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              load,
    input  logic              issue,
    input  op_t               ld_op,
    input  logic [DATA_W-1:0] ld_imm,
    input  logic [TAG_W-1:0]  ld_tag,
    input  logic [DATA_W-1:0] ld_v1,
    input  logic [TAG_W-1:0]  ld_q1,
    input  logic [DATA_W-1:0] ld_v2,
    input  logic [TAG_W-1:0]  ld_q2,
    input  logic              cdb_valid,
    input  logic [TAG_W-1:0]  cdb_tag,
    input  logic [DATA_W-1:0] cdb_data,
    output logic              busy,
    output logic              ready,
    output op_t               iss_op,
    output logic [DATA_W-1:0] iss_imm,
    output logic [TAG_W-1:0]  iss_tag,
    output logic [DATA_W-1:0] iss_v1,
    output logic [DATA_W-1:0] iss_v2
);

    logic [TAG_W-1:0]  q1;
    logic [TAG_W-1:0]  q2;
    logic [TAG_W-1:0]  cur_q1;
    logic [TAG_W-1:0]  cur_q2;
    logic [DATA_W-1:0] cur_v1;
    logic [DATA_W-1:0] cur_v2;
    logic              hit1;
    logic              hit2;

    // operands seen this cycle, fresh from the load bus or held.
    assign cur_q1 = load ? ld_q1 : q1;
    assign cur_v1 = load ? ld_v1 : iss_v1;
    assign cur_q2 = load ? ld_q2 : q2;
    assign cur_v2 = load ? ld_v2 : iss_v2;

    assign hit1 = cdb_valid && (cur_q1 != '0) && (cdb_tag == cur_q1);
    assign hit2 = cdb_valid && (cur_q2 != '0) && (cdb_tag == cur_q2);

    assign ready = busy && (q1 == '0) && (q2 == '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (issue) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            iss_op  <= ld_op;
            iss_imm <= ld_imm;
            iss_tag <= ld_tag;
        end
        q1     <= hit1 ? '0 : cur_q1;
        iss_v1 <= hit1 ? cdb_data : cur_v1;
        q2     <= hit2 ? '0 : cur_q2;
        iss_v2 <= hit2 ? cdb_data : cur_v2;
    end

endmodule

`default_nettype wire

// File: verification/ooo_core_asserts.sv
`default_nettype none

module ooo_core_asserts import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int SLOT_NUM  = 4
) (
    input logic                clk,
    input logic                rst,
    input logic                flush,
    input logic                in_ready,
    input logic                rob_full,
    input logic [SLOT_NUM-1:0] slot_load,
    input logic [SLOT_NUM-1:0] slot_issue,
    input logic                cdb_valid,
    input logic [TAG_W-1:0]    cdb_tag,
    input logic                commit_valid,
    input logic [TAG_W-1:0]    rob_commit_tag
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned      n_load  = 0;
    int unsigned      n_issue = 0;
    int unsigned      n_tag   = 0;
    int unsigned      n_ready = 0;
    int unsigned      n_flush = 0;
    int unsigned      n_order = 0;
    int unsigned      fail_count;
    logic [TAG_W-1:0] next_tag;

    assign fail_count = n_load + n_issue + n_tag + n_ready + n_flush + n_order;

    // tag expected at the next retirement, wraps after the last entry.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            next_tag <= TAG_W'(1);
        end else if (commit_valid) begin
            next_tag <= (next_tag == TAG_W'(ROB_DEPTH)) ? TAG_W'(1) : next_tag + TAG_W'(1);
        end
    end

    load_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(slot_load))
        else begin
            $error("slot_load selects more than one slot");
            n_load++;
        end

    issue_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(slot_issue))
        else begin
            $error("slot_issue selects more than one slot");
            n_issue++;
        end

    cdb_tag_set: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_tag != '0)
        else begin
            $error("result bus carries tag zero");
            n_tag++;
        end

    full_stalls: assert property (@(posedge clk) disable iff (rst) rob_full |-> !in_ready)
        else begin
            $error("in_ready high while the reorder buffer is full");
            n_ready++;
        end

    flush_quiet: assert property (@(posedge clk) disable iff (rst) flush |-> !commit_valid)
        else begin
            $error("commit during a flush cycle");
            n_flush++;
        end

    commit_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> rob_commit_tag == next_tag)
        else begin
            $error("commit tag out of program order");
            n_order++;
        end

endmodule

bind ooo_core ooo_core_asserts #(
    .ROB_DEPTH(ROB_DEPTH),
    .SLOT_NUM(SLOT_NUM)
) i_ooo_core_asserts (
    .clk(clk), .rst(rst), .flush(flush),
    .in_ready(in_ready), .rob_full(rob_full),
    .slot_load(slot_load), .slot_issue(slot_issue),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
    .commit_valid(commit_valid), .rob_commit_tag(rob_commit_tag)
);

`default_nettype wire

// File: verification/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              in_valid;
    op_t               in_op;
    logic [REG_W-1:0]  in_rd;
    logic [REG_W-1:0]  in_rs1;
    logic [REG_W-1:0]  in_rs2;
    logic [DATA_W-1:0] in_imm;
    logic              in_ready;
    logic              commit_valid;
    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;

    logic [DATA_W-1:0] spec_regs [8];          // model state in dispatch order.
    logic [DATA_W-1:0] arch_regs [8];          // retired state.
    logic [REG_W-1:0]  exp_rd_q [$];
    logic [DATA_W-1:0] exp_data_q [$];
    logic [REG_W-1:0]  exp_rd;
    logic [DATA_W-1:0] exp_data;
    int                errors;
    int                mismatches;
    int                timeouts;
    int                stall_cycles;

    ooo_core #(.ROB_DEPTH(8), .SLOT_NUM(4)) i_ooo_core (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_op(in_op), .in_rd(in_rd),
        .in_rs1(in_rs1), .in_rs2(in_rs2), .in_imm(in_imm),
        .in_ready(in_ready), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data)
    );

    always #10 clk = ~clk;

    function automatic logic [DATA_W-1:0] expected_result(input op_t op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
            input logic [DATA_W-1:0] imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            default: return a + imm;
        endcase
    endfunction

    // commits must arrive in dispatch order.
    always @(posedge clk) begin
        if (!rst && commit_valid) begin
            assert (exp_rd_q.size() != 0) else begin
                mismatches++;
                $display("unexpected commit to r%0d at %0t with nothing pending", commit_rd,
                         $time);
            end
            if (exp_rd_q.size() != 0) begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (commit_rd === exp_rd) else begin
                    mismatches++;
                    $display("FAILED %0t commit_rd expected %0d got %0d", $time, exp_rd,
                             commit_rd);
                end
                assert (commit_data === exp_data) else begin
                    mismatches++;
                    $display("FAILED %0t commit_data expected %h got %h", $time, exp_data,
                             commit_data);
                end
                if (exp_rd != '0) begin
                    arch_regs[exp_rd[2:0]] = exp_data;
                end
            end
        end
    end

    task automatic send(input op_t op, input logic [REG_W-1:0] rd,
            input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
            input logic [DATA_W-1:0] imm);
        int                waited;
        logic [DATA_W-1:0] res;
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            in_valid = 1'b0;
            stall_cycles++;
            waited++;
            @(negedge clk);
        end
        if (!in_ready) begin
            in_valid = 1'b0;
            timeouts++;
            $display("timeout at %0t: dispatch was never accepted", $time);
        end else begin
            res = expected_result(op, spec_regs[rs1[2:0]], spec_regs[rs2[2:0]], imm);
            if (rd != '0) begin
                spec_regs[rd[2:0]] = res;
            end
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
            in_valid = 1'b1;
            in_op    = op;
            in_rd    = rd;
            in_rs1   = rs1;
            in_rs2   = rs2;
            in_imm   = imm;
        end
    endtask

    task automatic send_random();
        send(op_t'($urandom_range(6, 0)), REG_W'($urandom_range(7, 0)),
             REG_W'($urandom_range(7, 0)), REG_W'($urandom_range(7, 0)), $urandom());
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_rd_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            timeouts++;
            $display("timeout at %0t: %0d instructions never committed", $time,
                     exp_rd_q.size());
            exp_rd_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic do_flush();
        @(negedge clk);
        in_valid = 1'b0;
        flush    = 1'b1;
        exp_rd_q.delete();                     // work in flight is discarded.
        exp_data_q.delete();
        spec_regs = arch_regs;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        void'($urandom(44360));
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_rd        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        errors       = 0;
        mismatches   = 0;
        timeouts     = 0;
        stall_cycles = 0;
        for (int i = 0; i < 8; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int r = 1; r < 8; r++) begin
            send(op_addi, REG_W'(r), '0, '0, $urandom());
        end
        for (int k = 0; k < 7; k++) begin      // every opcode, sources r1 to r4.
            send(op_t'(k), REG_W'(5 + k % 3), REG_W'(1 + k % 4), REG_W'(1 + (k + 1) % 4),
                 $urandom());
        end
        wait_drain();

        repeat (4) begin
            send(op_addi, 5'd1, 5'd1, 5'd0, 32'd3);
            send(op_add, 5'd2, 5'd1, 5'd2, '0);
            send(op_xor, 5'd3, 5'd2, 5'd1, '0);
            send(op_sub, 5'd1, 5'd3, 5'd2, '0);
        end
        repeat (30) send_random();
        wait_drain();

        send(op_add, 5'd7, 5'd7, 5'd1, '0);
        send(op_add, 5'd7, 5'd7, 5'd2, '0);
        send(op_addi, 5'd4, 5'd0, 5'd0, 32'd11);  // older r4, retires behind the r7 chain.
        send(op_add, 5'd6, 5'd7, 5'd1, '0);
        send(op_add, 5'd6, 5'd6, 5'd2, '0);
        send(op_add, 5'd4, 5'd6, 5'd3, '0);    // younger r4, still pending at that retire.
        repeat (4) send(op_add, 5'd5, 5'd4, 5'd0, '0);
        wait_drain();
        send(op_or, 5'd6, 5'd4, 5'd0, '0);
        wait_drain();

        stall_cycles = 0;
        repeat (20) send_random();
        wait_drain();
        assert (stall_cycles != 0) else begin
            errors++;
            $display("in_ready never dropped during the back-to-back burst");
        end

        send(op_addi, 5'd0, 5'd1, 5'd0, 32'd5);
        send(op_add, 5'd6, 5'd0, 5'd0, '0);
        send(op_or, 5'd7, 5'd0, 5'd2, '0);
        wait_drain();

        repeat (6) send_random();
        do_flush();
        repeat (10) @(negedge clk);            // any commit here is flagged.
        for (int r = 1; r < 8; r++) begin
            send(op_add, REG_W'(r), REG_W'(r), 5'd0, '0);
        end
        wait_drain();

        $display("errors %0d, commit mismatches %0d, timeouts %0d, assertion failures %0d",
                 errors, mismatches, timeouts, i_ooo_core.i_ooo_core_asserts.fail_count);
        if (errors + mismatches + timeouts + i_ooo_core.i_ooo_core_asserts.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
